/* fpu_pipe.f */
logic/fpu_pkg.sv
logic/fpu_issue_queue.sv
logic/fpu_cmp_unit.sv
logic/fpu_sgn_unit.sv
logic/fpu_wb_arb.sv
logic/fpu_pipe.sv
sim/fpu_pipe_props.sv
sim/fpu_pipe_tb.sv

/* logic/fpu_cmp_unit.sv */
`timescale 1ns/100ps
// FP compare unit: feq, flt, fle, fmin, fmax
// Single stage with a one-deep result register
module fpu_cmp_unit
#(
   parameter int ROB_ID_W = 4
)
(
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_flush,
   input  logic                  i_valid,
   output logic                  o_ready,
   input  fpu_pkg::fpu_exec_s    i_exec,
   input  logic [ROB_ID_W-1:0]   i_id,
   output logic                  o_valid,
   input  logic                  i_ready,
   output fpu_pkg::fpu_data_t    o_result,
   output logic [ROB_ID_W-1:0]   o_id
);

   fpu_pkg::fpu_data_t a, b;
   fpu_pkg::fpu_data_t res;
   logic a_nan, b_nan, any_nan;
   logic both_zero;     // +0 / -0 in any combination
   logic lt_ord;        // a below b, -0 below +0
   logic feq, flt;
   logic pick_a;        // fmin/fmax chooses a

   assign a = i_exec.a;
   assign b = i_exec.b;

   assign a_nan     = (a[30:23] == 8'hFF) && (a[22:0] != '0);
   assign b_nan     = (b[30:23] == 8'hFF) && (b[22:0] != '0);
   assign any_nan   = a_nan | b_nan;
   assign both_zero = ((a[30:0] | b[30:0]) == '0);

   // Sign first, then magnitude, reversed for negatives
   assign lt_ord = (a[31] != b[31]) ? a[31] :
                   (a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]));

   assign feq = ~any_nan & ((a == b) | both_zero);
   assign flt = ~any_nan & ~both_zero & lt_ord;

   // NaN side loses, else order decides
   assign pick_a = a_nan ? 1'b0 :
                   b_nan ? 1'b1 :
                   (lt_ord ^ (i_exec.uop == fpu_pkg::UOP_FMAX));

   always_comb
   begin
      case (i_exec.uop)
         fpu_pkg::UOP_FEQ: res = feq ? fpu_pkg::RES_ONE : fpu_pkg::RES_ZERO;
         fpu_pkg::UOP_FLT: res = flt ? fpu_pkg::RES_ONE : fpu_pkg::RES_ZERO;
         fpu_pkg::UOP_FLE: res = (flt | feq) ? fpu_pkg::RES_ONE : fpu_pkg::RES_ZERO;
         fpu_pkg::UOP_FMIN,
         fpu_pkg::UOP_FMAX:
         begin
            if (a_nan & b_nan)
               res = fpu_pkg::CANON_NAN;   // Both NaN
            else
               res = pick_a ? a : b;
         end
         default: res = fpu_pkg::RES_ZERO;
      endcase
   end

   assign o_ready = ~o_valid | i_ready;   // Empty or draining

   always_ff @(posedge clk)
   begin
      if (i_rst | i_flush)
         o_valid <= 1'b0;
      else if (o_ready)
         o_valid <= i_valid;
   end

   always_ff @(posedge clk)
   begin
      if (i_valid & o_ready)
      begin
         o_result <= res;
         o_id     <= i_id;
      end
   end

endmodule

/* logic/fpu_issue_queue.sv */
`timescale 1ns/100ps
// FP issue queue, out of order
// Holds dispatched uops, wakes operands from the bypass bus, issues to two units
module fpu_issue_queue
#(
   parameter int ROB_ID_W    = 4,
   parameter int QDEPTH_LOG2 = 2
)
(
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_flush,
   // Dispatch side
   input  logic                  i_issue_valid,
   output logic                  o_issue_ready,
   input  fpu_pkg::fpu_issue_s   i_issue,
   input  logic [ROB_ID_W-1:0]   i_issue_id,
   // Bypass broadcast
   input  fpu_pkg::fpu_byp_s     i_byp,
   // Unit side
   output logic                  o_cmp_valid,
   input  logic                  i_cmp_ready,
   output logic                  o_sgn_valid,
   input  logic                  i_sgn_ready,
   output fpu_pkg::fpu_exec_s    o_exec,
   output logic [ROB_ID_W-1:0]   o_exec_id
);

   localparam int QDEPTH = 1 << QDEPTH_LOG2;

   logic [QDEPTH-1:0]      ent_vld;                // Entry occupied
   logic [ROB_ID_W-1:0]    ent_id [QDEPTH];
   fpu_pkg::fpu_issue_s    ent_pl [QDEPTH];        // Uop and operands
   logic [QDEPTH-1:0]      ent_sgn;                // Targets sign unit
   logic [QDEPTH-1:0]      ent_go;                 // Ready and unit can take it
   logic [QDEPTH_LOG2-1:0] free_idx;
   logic [QDEPTH_LOG2-1:0] sel_idx;
   logic                   sel_found;
   logic                   dsp_fire;
   fpu_pkg::fpu_issue_s    dsp_pl;                 // Dispatch after same-cycle wakeup

   // Sign-class ops go to the sign unit, everything else to compare
   function automatic logic uop_is_sgn(input fpu_pkg::fpu_uop_t uop);
      return (uop == fpu_pkg::UOP_FSGNJ)  || (uop == fpu_pkg::UOP_FSGNJN) ||
             (uop == fpu_pkg::UOP_FSGNJX) || (uop == fpu_pkg::UOP_FCLASS);
   endfunction

   // Capture bypass data into a waiting operand on address match
   function automatic fpu_pkg::fpu_opnd_s opnd_wake(input fpu_pkg::fpu_opnd_s op,
                                                    input fpu_pkg::fpu_byp_s  byp);
      fpu_pkg::fpu_opnd_s res;
      res = op;
      if (!op.rdy && byp.valid && (byp.addr == op.addr))
      begin
         res.rdy = 1'b1;
         res.dat = byp.dat;
      end
      return res;
   endfunction

   assign o_issue_ready = ~&ent_vld;                      // Any free slot
   assign dsp_fire      = i_issue_valid & o_issue_ready & ~i_flush; // Flush wins

   always_comb
   begin
      dsp_pl     = i_issue;
      dsp_pl.rs1 = opnd_wake(i_issue.rs1, i_byp);         // Wakeup on acceptance cycle
      dsp_pl.rs2 = opnd_wake(i_issue.rs2, i_byp);
   end

   // Lowest free slot
   always_comb
   begin
      free_idx = '0;
      for (int i = QDEPTH-1; i >= 0; i--)
         if (!ent_vld[i])
            free_idx = QDEPTH_LOG2'(i);
   end

   // Per-entry readiness
   always_comb
   begin
      for (int i = 0; i < QDEPTH; i++)
      begin
         ent_sgn[i] = uop_is_sgn(ent_pl[i].uop);
         ent_go[i]  = ent_vld[i] & ent_pl[i].rs1.rdy & ent_pl[i].rs2.rdy &
                      (ent_sgn[i] ? i_sgn_ready : i_cmp_ready);
      end
   end

   // Oldest by index wins
   always_comb
   begin
      sel_found = 1'b0;
      sel_idx   = '0;
      for (int i = QDEPTH-1; i >= 0; i--)
      begin
         if (ent_go[i])
         begin
            sel_found = 1'b1;
            sel_idx   = QDEPTH_LOG2'(i);
         end
      end
   end

   assign o_cmp_valid = sel_found & ~ent_sgn[sel_idx];
   assign o_sgn_valid = sel_found &  ent_sgn[sel_idx];
   assign o_exec_id   = ent_id[sel_idx];

   always_comb
   begin
      o_exec.uop = ent_pl[sel_idx].uop;
      o_exec.a   = ent_pl[sel_idx].rs1.dat;
      o_exec.b   = ent_pl[sel_idx].rs2.dat;
   end

   // Occupancy
   always_ff @(posedge clk)
   begin
      if (i_rst | i_flush)
         ent_vld <= '0;
      else
      begin
         if (sel_found)
            ent_vld[sel_idx] <= 1'b0;    // Issued, slot freed
         if (dsp_fire)
            ent_vld[free_idx] <= 1'b1;   // Never the issuing slot
      end
   end

   // Payload write and wakeup
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < QDEPTH; i++)
      begin
         if (dsp_fire && (free_idx == QDEPTH_LOG2'(i)))
         begin
            ent_pl[i] <= dsp_pl;
            ent_id[i] <= i_issue_id;
         end
         else
         begin
            ent_pl[i].rs1 <= opnd_wake(ent_pl[i].rs1, i_byp);
            ent_pl[i].rs2 <= opnd_wake(ent_pl[i].rs2, i_byp);
         end
      end
   end

endmodule

/* logic/fpu_pipe.sv */
`timescale 1ns/100ps
// FP issue pipeline top: issue queue, compare and sign units, writeback arbiter
module fpu_pipe
#(
   parameter int ROB_ID_W    = 4,
   parameter int QDEPTH_LOG2 = 2
)
(
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_flush,
   // Dispatch
   input  logic                  i_issue_valid,
   output logic                  o_issue_ready,
   input  fpu_pkg::fpu_issue_s   i_issue,
   input  logic [ROB_ID_W-1:0]   i_issue_id,
   // Bypass
   input  fpu_pkg::fpu_byp_s     i_byp,
   // Writeback
   output logic                  o_wb_valid,
   input  logic                  i_wb_ready,
   output fpu_pkg::fpu_data_t    o_wb_data,
   output logic [ROB_ID_W-1:0]   o_wb_id
);

   // Queue to units
   logic                  cmp_req_valid, cmp_req_ready;
   logic                  sgn_req_valid, sgn_req_ready;
   fpu_pkg::fpu_exec_s    exec_req;        // Shared by both units
   logic [ROB_ID_W-1:0]   exec_id;
   // Units to arbiter
   logic                  cmp_res_valid, cmp_res_ready;
   fpu_pkg::fpu_data_t    cmp_result;
   logic [ROB_ID_W-1:0]   cmp_id;
   logic                  sgn_res_valid, sgn_res_ready;
   fpu_pkg::fpu_data_t    sgn_result;
   logic [ROB_ID_W-1:0]   sgn_id;

   fpu_issue_queue
      #(
         .ROB_ID_W      (ROB_ID_W),
         .QDEPTH_LOG2   (QDEPTH_LOG2)
      )
   issue_queue0
      (
         .clk           (clk),
         .i_rst         (i_rst),
         .i_flush       (i_flush),
         .i_issue_valid (i_issue_valid),
         .o_issue_ready (o_issue_ready),
         .i_issue       (i_issue),
         .i_issue_id    (i_issue_id),
         .i_byp         (i_byp),
         .o_cmp_valid   (cmp_req_valid),
         .i_cmp_ready   (cmp_req_ready),
         .o_sgn_valid   (sgn_req_valid),
         .i_sgn_ready   (sgn_req_ready),
         .o_exec        (exec_req),
         .o_exec_id     (exec_id)
      );

   fpu_cmp_unit
      #(
         .ROB_ID_W      (ROB_ID_W)
      )
   cmp_unit0
      (
         .clk           (clk),
         .i_rst         (i_rst),
         .i_flush       (i_flush),
         .i_valid       (cmp_req_valid),
         .o_ready       (cmp_req_ready),
         .i_exec        (exec_req),
         .i_id          (exec_id),
         .o_valid       (cmp_res_valid),
         .i_ready       (cmp_res_ready),
         .o_result      (cmp_result),
         .o_id          (cmp_id)
      );

   fpu_sgn_unit
      #(
         .ROB_ID_W      (ROB_ID_W)
      )
   sgn_unit0
      (
         .clk           (clk),
         .i_rst         (i_rst),
         .i_flush       (i_flush),
         .i_valid       (sgn_req_valid),
         .o_ready       (sgn_req_ready),
         .i_exec        (exec_req),
         .i_id          (exec_id),
         .o_valid       (sgn_res_valid),
         .i_ready       (sgn_res_ready),
         .o_result      (sgn_result),
         .o_id          (sgn_id)
      );

   fpu_wb_arb
      #(
         .ROB_ID_W      (ROB_ID_W)
      )
   wb_arb0
      (
         .clk           (clk),
         .i_rst         (i_rst),
         .i_flush       (i_flush),
         .i_cmp_valid   (cmp_res_valid),
         .o_cmp_ready   (cmp_res_ready),
         .i_cmp_result  (cmp_result),
         .i_cmp_id      (cmp_id),
         .i_sgn_valid   (sgn_res_valid),
         .o_sgn_ready   (sgn_res_ready),
         .i_sgn_result  (sgn_result),
         .i_sgn_id      (sgn_id),
         .o_wb_valid    (o_wb_valid),
         .i_wb_ready    (i_wb_ready),
         .o_wb_data     (o_wb_data),
         .o_wb_id       (o_wb_id)
      );

endmodule

/* logic/fpu_pkg.sv */
// Shared types for the FPU issue pipeline
// Operand, dispatch, bypass and execute payloads plus micro-op codes
package fpu_pkg;

   typedef logic [31:0] fpu_data_t;      // IEEE single value
   typedef logic [4:0]  fpu_reg_addr_t;  // Architectural FP register
   typedef logic [3:0]  fpu_uop_t;       // Micro-op code

   // Compare unit ops
   localparam fpu_uop_t UOP_FEQ    = 4'd1;
   localparam fpu_uop_t UOP_FLT    = 4'd2;
   localparam fpu_uop_t UOP_FLE    = 4'd3;
   localparam fpu_uop_t UOP_FMIN   = 4'd4;
   localparam fpu_uop_t UOP_FMAX   = 4'd5;

   // Sign unit ops
   localparam fpu_uop_t UOP_FSGNJ  = 4'd8;
   localparam fpu_uop_t UOP_FSGNJN = 4'd9;
   localparam fpu_uop_t UOP_FSGNJX = 4'd10;
   localparam fpu_uop_t UOP_FCLASS = 4'd11;

   // One source operand, 38 bits
   typedef struct packed
   {
      logic          rdy;   // Value present
      fpu_reg_addr_t addr;  // Source reg, for wakeup match
      fpu_data_t     dat;
   } fpu_opnd_s;

   // Dispatch payload, 80 bits
   typedef struct packed
   {
      fpu_uop_t  uop;
      fpu_opnd_s rs1;
      fpu_opnd_s rs2;
   } fpu_issue_s;

   // Bypass broadcast, 38 bits
   typedef struct packed
   {
      logic          valid;
      fpu_reg_addr_t addr;
      fpu_data_t     dat;
   } fpu_byp_s;

   // Unit request, 68 bits
   typedef struct packed
   {
      fpu_uop_t  uop;
      fpu_data_t a;
      fpu_data_t b;
   } fpu_exec_s;

   // Result constants
   localparam fpu_data_t CANON_NAN = 32'h7FC0_0000;  // Canonical quiet NaN
   localparam fpu_data_t RES_ONE   = 32'd1;          // Compare true
   localparam fpu_data_t RES_ZERO  = 32'd0;          // Compare false

endpackage

/* logic/fpu_sgn_unit.sv */
`timescale 1ns/100ps
// FP sign unit: sign injection and classify
// Single stage with a one-deep result register
module fpu_sgn_unit
#(
   parameter int ROB_ID_W = 4
)
(
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_flush,
   input  logic                  i_valid,
   output logic                  o_ready,
   input  fpu_pkg::fpu_exec_s    i_exec,
   input  logic [ROB_ID_W-1:0]   i_id,
   output logic                  o_valid,
   input  logic                  i_ready,
   output fpu_pkg::fpu_data_t    o_result,
   output logic [ROB_ID_W-1:0]   o_id
);

   fpu_pkg::fpu_data_t a, b;
   fpu_pkg::fpu_data_t res;
   logic       exp_ones, exp_zero, man_zero;
   logic [9:0] cls;     // RISC-V fclass one-hot

   assign a = i_exec.a;
   assign b = i_exec.b;

   assign exp_ones = (a[30:23] == 8'hFF);
   assign exp_zero = (a[30:23] == 8'h00);
   assign man_zero = (a[22:0] == '0);

   assign cls[0] =  a[31] & exp_ones & man_zero;      // -inf
   assign cls[1] =  a[31] & ~exp_ones & ~exp_zero;    // -normal
   assign cls[2] =  a[31] & exp_zero & ~man_zero;     // -subnormal
   assign cls[3] =  a[31] & exp_zero & man_zero;      // -0
   assign cls[4] = ~a[31] & exp_zero & man_zero;      // +0
   assign cls[5] = ~a[31] & exp_zero & ~man_zero;     // +subnormal
   assign cls[6] = ~a[31] & ~exp_ones & ~exp_zero;    // +normal
   assign cls[7] = ~a[31] & exp_ones & man_zero;      // +inf
   assign cls[8] = exp_ones & ~man_zero & ~a[22];     // Signalling NaN
   assign cls[9] = exp_ones & a[22];                  // Quiet NaN

   always_comb
   begin
      case (i_exec.uop)
         fpu_pkg::UOP_FSGNJ:  res = {b[31], a[30:0]};
         fpu_pkg::UOP_FSGNJN: res = {~b[31], a[30:0]};
         fpu_pkg::UOP_FSGNJX: res = {a[31] ^ b[31], a[30:0]};
         fpu_pkg::UOP_FCLASS: res = {22'd0, cls};
         default:             res = '0;
      endcase
   end

   assign o_ready = ~o_valid | i_ready;

   always_ff @(posedge clk)
   begin
      if (i_rst | i_flush)
         o_valid <= 1'b0;
      else if (o_ready)
         o_valid <= i_valid;   // Load or drain
   end

   always_ff @(posedge clk)
   begin
      if (i_valid & o_ready)
      begin
         o_result <= res;
         o_id     <= i_id;
      end
   end

endmodule

/* logic/fpu_wb_arb.sv */
`timescale 1ns/100ps
// Writeback arbiter for the compare and sign units
// Alternating priority, registered writeback port
module fpu_wb_arb
#(
   parameter int ROB_ID_W = 4
)
(
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_flush,
   // Compare unit
   input  logic                  i_cmp_valid,
   output logic                  o_cmp_ready,
   input  fpu_pkg::fpu_data_t    i_cmp_result,
   input  logic [ROB_ID_W-1:0]   i_cmp_id,
   // Sign unit
   input  logic                  i_sgn_valid,
   output logic                  o_sgn_ready,
   input  fpu_pkg::fpu_data_t    i_sgn_result,
   input  logic [ROB_ID_W-1:0]   i_sgn_id,
   // Writeback
   output logic                  o_wb_valid,
   input  logic                  i_wb_ready,
   output fpu_pkg::fpu_data_t    o_wb_data,
   output logic [ROB_ID_W-1:0]   o_wb_id
);

   logic last_sgn;     // Sign unit won the last grant
   logic load_en;      // Output register free this cycle
   logic gnt_cmp;
   logic gnt_sgn;

   assign load_en = ~o_wb_valid | i_wb_ready;

   // On a tie the previous loser goes first
   assign gnt_cmp = i_cmp_valid & (~i_sgn_valid | last_sgn);
   assign gnt_sgn = i_sgn_valid & (~i_cmp_valid | ~last_sgn);

   assign o_cmp_ready = load_en & gnt_cmp;
   assign o_sgn_ready = load_en & gnt_sgn;

   always_ff @(posedge clk)
   begin
      if (i_rst | i_flush)
         o_wb_valid <= 1'b0;
      else if (load_en)
         o_wb_valid <= gnt_cmp | gnt_sgn;   // Held while stalled
   end

   always_ff @(posedge clk)
   begin
      if (i_rst)
         last_sgn <= 1'b0;
      else if (load_en & (gnt_cmp | gnt_sgn))
         last_sgn <= gnt_sgn;
   end

   // Payload only moves on a grant
   always_ff @(posedge clk)
   begin
      if (o_cmp_ready)
      begin
         o_wb_data <= i_cmp_result;
         o_wb_id   <= i_cmp_id;
      end
      else if (o_sgn_ready)
      begin
         o_wb_data <= i_sgn_result;
         o_wb_id   <= i_sgn_id;
      end
   end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fpu_pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module fpu_pipe_tb -f fpu_pipe.f -Mdir obj_dir > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vfpu_pipe_tb > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log \
   && { echo "Run failed"; exit 1; } \
   || grep -q "SIMULATION PASSED" sim.log \
   || { echo "Run ended without a result"; exit 1; }

/* sim/fpu_pipe_props.sv */
`timescale 1ns/100ps
// Handshake and flush properties for the FPU issue pipeline
module fpu_pipe_props
#(
   parameter int ROB_ID_W    = 4,
   parameter int QDEPTH_LOG2 = 2
)
(
   input logic                        clk,
   input logic                        i_rst,
   input logic                        i_flush,
   input logic                        i_issue_valid,
   input logic                        o_issue_ready,
   input logic                        o_wb_valid,
   input logic                        i_wb_ready,
   input logic [31:0]                 o_wb_data,
   input logic [ROB_ID_W-1:0]         o_wb_id,
   // Queue to unit handshakes
   input logic                        i_cmp_req_valid,
   input logic                        i_cmp_req_ready,
   input logic                        i_sgn_req_valid,
   input logic                        i_sgn_req_ready
);

   localparam int QDEPTH = 1 << QDEPTH_LOG2;

   logic                 enq;   // Dispatch accepted
   logic                 deq;   // Entry sent to a unit
   logic [QDEPTH_LOG2:0] occ;   // Queue entries in use

   assign enq = i_issue_valid & o_issue_ready;
   assign deq = (i_cmp_req_valid & i_cmp_req_ready) | (i_sgn_req_valid & i_sgn_req_ready);

   // Occupancy counted from the handshakes alone
   always_ff @(posedge clk)
   begin
      if (i_rst | i_flush)
         occ <= '0;
      else if (enq & ~deq)
         occ <= occ + 1'b1;
      else if (deq & ~enq)
         occ <= occ - 1'b1;
   end

   // Stalled writeback holds its payload
   wb_hold: assert property (@(posedge clk) disable iff (i_rst)
      (o_wb_valid && !i_wb_ready && !i_flush) |=>
         (o_wb_valid && $stable(o_wb_data) && $stable(o_wb_id)))
      else $error("writeback payload changed while stalled");

   wb_clear: assert property (@(posedge clk) (i_rst || i_flush) |=> !o_wb_valid)
      else $error("writeback valid after reset or flush");

   // Full queue accepts nothing
   full_block: assert property (@(posedge clk) disable iff (i_rst)
      (occ == QDEPTH) |-> !(o_issue_ready && i_issue_valid))
      else $error("dispatch accepted with queue full");

endmodule

bind fpu_pipe fpu_pipe_props #(.ROB_ID_W(ROB_ID_W), .QDEPTH_LOG2(QDEPTH_LOG2)) props0
(
   .clk             (clk),
   .i_rst           (i_rst),
   .i_flush         (i_flush),
   .i_issue_valid   (i_issue_valid),
   .o_issue_ready   (o_issue_ready),
   .o_wb_valid      (o_wb_valid),
   .i_wb_ready      (i_wb_ready),
   .o_wb_data       (o_wb_data),
   .o_wb_id         (o_wb_id),
   .i_cmp_req_valid (cmp_req_valid),
   .i_cmp_req_ready (cmp_req_ready),
   .i_sgn_req_valid (sgn_req_valid),
   .i_sgn_req_ready (sgn_req_ready)
);

/* sim/fpu_pipe_tb.sv */
`timescale 1ns/100ps
// Testbench for the FPU issue pipeline
// Table-driven dispatch, bypass wakeup, random writeback stalls, ID scoreboard
module fpu_pipe_tb;

   localparam int ROB_ID_W = 4;
   localparam int NID      = 1 << ROB_ID_W;
   localparam logic [7:0] NEVER = 8'hFF;   // Bypass never sent

   typedef struct packed
   {
      fpu_pkg::fpu_uop_t      uop;
      fpu_pkg::fpu_data_t     a;
      fpu_pkg::fpu_data_t     b;
      logic                   r1;     // rs1 ready at dispatch
      logic                   r2;
      fpu_pkg::fpu_reg_addr_t ad1;
      fpu_pkg::fpu_reg_addr_t ad2;
      logic [7:0]             dly;    // Bypass delay after acceptance
      logic                   fl;     // Flush right after dispatch
   } row_t;

   logic                       clk;
   logic                       i_rst;
   logic                       i_flush;
   logic                       i_issue_valid;
   logic                       o_issue_ready;
   fpu_pkg::fpu_issue_s        i_issue;
   logic [ROB_ID_W-1:0]        i_issue_id;
   fpu_pkg::fpu_byp_s          i_byp;
   logic                       o_wb_valid;
   logic                       i_wb_ready;
   fpu_pkg::fpu_data_t         o_wb_data;
   logic [ROB_ID_W-1:0]        o_wb_id;

   row_t                       rows[$];
   logic [NID-1:0]             pend;            // Scoreboard of IDs in flight
   fpu_pkg::fpu_data_t         expv [NID];
   int                         wq_due[$];       // Scheduled bypasses
   fpu_pkg::fpu_byp_s          wq_byp[$];
   logic [15:0]                lfsr = 16'd51837;
   int                         cycles = 0;
   int                         n_err = 0;
   int                         n_wb = 0;
   logic                       rst_done = 1'b0;
   logic                       saw_full = 1'b0;
   logic                       byp_hold = 1'b0; // Same-cycle bypass owns the bus

   fpu_pipe #(.ROB_ID_W(ROB_ID_W), .QDEPTH_LOG2(2)) dut0
   (
      .clk(clk), .i_rst(i_rst), .i_flush(i_flush),
      .i_issue_valid(i_issue_valid), .o_issue_ready(o_issue_ready),
      .i_issue(i_issue), .i_issue_id(i_issue_id), .i_byp(i_byp),
      .o_wb_valid(o_wb_valid), .i_wb_ready(i_wb_ready),
      .o_wb_data(o_wb_data), .o_wb_id(o_wb_id)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_fail(input string what);
      n_err++;
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   // Galois LFSR stepped once per bit
   function automatic logic lfsr_bit();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
         lfsr = lfsr ^ 16'hB400;
      return b;
   endfunction

   // Total order key with both zeros on one point
   function automatic logic [31:0] order_key(input logic [31:0] x);
      if (x[30:0] == '0)
         return 32'h8000_0000;
      return x[31] ? ~x : (x | 32'h8000_0000);
   endfunction

   function automatic logic is_nan(input logic [31:0] x);
      return (x[30:23] == 8'hFF) && (x[22:0] != '0);
   endfunction

   function automatic logic [31:0] class_of(input logic [31:0] x);
      int k;
      if (is_nan(x))
         k = x[22] ? 9 : 8;
      else if (x[30:23] == 8'hFF)
         k = x[31] ? 0 : 7;                          // Infinities
      else if (x[30:23] != 8'h00)
         k = x[31] ? 1 : 6;                          // Normals
      else if (x[22:0] != '0)
         k = x[31] ? 2 : 5;                          // Subnormals
      else
         k = x[31] ? 3 : 4;                          // Zeros
      return 32'd1 << k;
   endfunction

   // Expected result straight from the op definitions
   function automatic logic [31:0] expect_result(input logic [3:0] uop,
                                                 input logic [31:0] a, input logic [31:0] b);
      logic nan, lt, eq, zz;
      nan = is_nan(a) || is_nan(b);
      lt  = !nan && (order_key(a) < order_key(b));
      eq  = !nan && (order_key(a) == order_key(b));
      zz  = (a[30:0] == '0) && (b[30:0] == '0);
      case (uop)
         fpu_pkg::UOP_FEQ:    return {31'd0, eq};
         fpu_pkg::UOP_FLT:    return {31'd0, lt};
         fpu_pkg::UOP_FLE:    return {31'd0, lt | eq};
         fpu_pkg::UOP_FMIN, fpu_pkg::UOP_FMAX:
         begin
            if (is_nan(a) && is_nan(b))
               return 32'h7FC0_0000;
            if (is_nan(a))
               return b;
            if (is_nan(b))
               return a;
            if (zz)                                  // -0 is the smaller zero
               return ((uop == fpu_pkg::UOP_FMIN) == a[31]) ? a : b;
            return ((uop == fpu_pkg::UOP_FMIN) == lt) ? a : b;
         end
         fpu_pkg::UOP_FSGNJ:  return (a & 32'h7FFF_FFFF) | (b & 32'h8000_0000);
         fpu_pkg::UOP_FSGNJN: return (a & 32'h7FFF_FFFF) | (~b & 32'h8000_0000);
         fpu_pkg::UOP_FSGNJX: return a ^ (b & 32'h8000_0000);
         fpu_pkg::UOP_FCLASS: return class_of(a);
         default:             return 32'd0;
      endcase
   endfunction

   task automatic add(input logic [3:0] uop, input logic [31:0] a, input logic [31:0] b,
                      input logic r1, input logic r2, input logic [4:0] ad1,
                      input logic [4:0] ad2, input logic [7:0] dly, input logic fl);
      rows.push_back({uop, a, b, r1, r2, ad1, ad2, dly, fl});
   endtask

   // Next drive point just after the rising edge
   task automatic tick();
      @(posedge clk);
      #10;
      i_wb_ready = lfsr_bit() | lfsr_bit();          // About 75 percent ready
      if (!byp_hold)
      begin
         i_byp = '0;
         if (wq_due.size() > 0 && wq_due[0] <= cycles)
         begin
            i_byp = wq_byp.pop_front();
            void'(wq_due.pop_front());
         end
      end
   endtask

   task automatic drive_row(input int n);
      row_t r;
      logic [ROB_ID_W-1:0] id;
      logic acc;
      fpu_pkg::fpu_byp_s byp;
      r   = rows[n];
      id  = ROB_ID_W'(n);
      byp = {1'b1, r.r1 ? r.ad2 : r.ad1, r.r1 ? r.b : r.a};
      while (pend[id])                               // ID still in flight
         tick();
      i_issue.uop = r.uop;
      i_issue.rs1 = {r.r1, r.ad1, r.r1 ? r.a : 32'hDEAD_BEEF};
      i_issue.rs2 = {r.r2, r.ad2, r.r2 ? r.b : 32'hDEAD_BEEF};
      i_issue_id  = id;
      i_issue_valid = 1'b1;
      byp_hold = (r.dly == 8'd0);
      do
      begin
         if (byp_hold)
            i_byp = byp;
         acc = o_issue_ready;
         tick();
      end
      while (!acc);
      i_issue_valid = 1'b0;
      if (byp_hold)
         i_byp = '0;
      byp_hold = 1'b0;
      pend[id] = 1'b1;
      expv[id] = expect_result(r.uop, r.a, r.b);
      if (r.dly != 8'd0 && r.dly != NEVER)
      begin
         wq_due.push_back(cycles + int'(r.dly));
         wq_byp.push_back(byp);
      end
      if (r.fl)
      begin
         tick();
         i_flush = 1'b1;
         tick();
         i_flush = 1'b0;
         pend = '0;                                  // Everything in flight dropped
         // Pending bypasses still go out and must wake nothing
      end
   endtask

   // Writeback monitor and scoreboard
   always @(posedge clk)
   begin
      if (rst_done && !o_issue_ready)
         saw_full <= 1'b1;
      if (rst_done && o_wb_valid && i_wb_ready)
      begin
         assert (pend[o_wb_id])
         else
            report_fail($sformatf("Writeback for ID %0h that is not in flight", o_wb_id));
         assert (o_wb_data == expv[o_wb_id])
         else
            report_fail($sformatf("Fail o_wb_data id %h got %h expected %h",
                                  o_wb_id, o_wb_data, expv[o_wb_id]));
         pend[o_wb_id] = 1'b0;
         n_wb++;
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles > 40 * rows.size() + 200)
         report_fail("Timeout, the writebacks did not finish in time");
   end

   initial
   begin
      i_rst = 1'b1;
      i_flush = 1'b0;
      i_issue_valid = 1'b0;
      i_issue = '0;
      i_issue_id = '0;
      i_byp = '0;
      i_wb_ready = 1'b0;
      pend = '0;
      // Compare ops
      add(fpu_pkg::UOP_FEQ,  32'h3F80_0000, 32'h3F80_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FEQ,  32'h8000_0000, 32'h0000_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FLT,  32'hBF80_0000, 32'h3F80_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FLE,  32'h7FC0_0000, 32'h3F80_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FLT,  32'h4000_0000, 32'h3F80_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FMIN, 32'h7FC0_0000, 32'h4040_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FMAX, 32'h7F80_0001, 32'h7FC0_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FMIN, 32'h0000_0000, 32'h8000_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FMAX, 32'h8000_0000, 32'h0000_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FMIN, 32'hC000_0000, 32'hBF80_0000, 1, 1, 0, 0, NEVER, 0);
      // Sign injection then one fclass per class
      add(fpu_pkg::UOP_FSGNJ,  32'h3F80_0000, 32'h8000_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FSGNJN, 32'hBF80_0000, 32'h8000_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FSGNJX, 32'hBF80_0000, 32'hC000_0000, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'hFF80_0000, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'hBF80_0000, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'h8000_0001, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'h8000_0000, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'h0000_0000, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'h0000_0001, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'h3F80_0000, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'h7F80_0000, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'h7F80_0001, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FCLASS, 32'h7FC0_0000, 0, 1, 1, 0, 0, NEVER, 0);
      // Bypass wakeup after a delay and in the same cycle
      add(fpu_pkg::UOP_FLT,   32'h3F80_0000, 32'h4000_0000, 0, 1, 5'd1, 0, 8'd5, 0);
      add(fpu_pkg::UOP_FSGNJ, 32'h4040_0000, 32'h8000_0000, 1, 0, 0, 5'd2, 8'd0, 0);
      // Flush with work in flight
      add(fpu_pkg::UOP_FMAX, 32'h3F80_0000, 32'h4000_0000, 0, 1, 5'd3, 0, 8'd6, 0);
      add(fpu_pkg::UOP_FEQ,  32'h3F80_0000, 32'h3F80_0000, 0, 1, 5'd4, 0, 8'd4, 1);
      // Fill the queue with waiting entries
      add(fpu_pkg::UOP_FMAX,   32'h4000_0000, 32'h3F80_0000, 1, 0, 0, 5'd10, 8'd25, 0);
      add(fpu_pkg::UOP_FMIN,   32'h4000_0000, 32'hBF80_0000, 1, 0, 0, 5'd11, 8'd26, 0);
      add(fpu_pkg::UOP_FSGNJX, 32'h4000_0000, 32'h8000_0000, 1, 0, 0, 5'd12, 8'd27, 0);
      add(fpu_pkg::UOP_FLE,    32'h4000_0000, 32'h4000_0000, 1, 0, 0, 5'd13, 8'd28, 0);
      add(fpu_pkg::UOP_FCLASS, 32'hC000_0000, 0, 1, 1, 0, 0, NEVER, 0);
      add(fpu_pkg::UOP_FLT,    32'h8000_0000, 32'h0000_0000, 1, 1, 0, 0, NEVER, 0);
      repeat (8)
         @(posedge clk);
      #10;
      i_rst = 1'b0;
      rst_done = 1'b1;
      for (int n = 0; n < rows.size(); n++)
         drive_row(n);
      while (pend != '0)
         tick();
      repeat (10)                                    // Catch stray writebacks
         tick();
      assert (saw_full)
      else
         report_fail("Issue ready never fell while the queue held waiting entries");
      if (n_err == 0)
      begin
         $display("%0d writebacks checked", n_wb);
         $display("SIMULATION PASSED");
      end
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule
